//--- hdl/exec_cfg_pkg.sv
// Widths shared by the integer execution back end
// Imported by every RTL block that carries operands, results or ids
`default_nettype none

package exec_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath sizing

    // Register width, RV32
    localparam int unsigned XLEN = 32;

    // Instruction tag width, up to 8 in flight
    localparam int unsigned ID_W = 3;

    ////////////////////////////////////////////////////////////////////////////
    // Width types

    // Operand or result word
    typedef logic [XLEN-1:0] word_t;

    // Tag that travels with an instruction to writeback
    typedef logic [ID_W-1:0] id_t;

endpackage

`default_nettype wire

//--- hdl/rv_isa_pkg.sv
// RISC-V encodings for the OP major opcode and the M extension multiplies
// Also holds the writeback arbiter state type
`default_nettype none

package rv_isa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction fields

    typedef logic [31:0] instr_t;
    typedef logic [2:0]  fn3_t;

    // R-type register-register major opcode
    localparam logic [6:0] OPC_OP = 7'b0110011;

    // funct7 variants
    localparam logic [6:0] FN7_BASE   = 7'b0000000;
    localparam logic [6:0] FN7_ALT    = 7'b0100000;
    localparam logic [6:0] FN7_MULDIV = 7'b0000001;

    ////////////////////////////////////////////////////////////////////////////
    // funct3 codes

    // Multiplies under FN7_MULDIV
    localparam fn3_t MUL_FN3    = 3'd0;
    localparam fn3_t MULH_FN3   = 3'd1;
    localparam fn3_t MULHSU_FN3 = 3'd2;
    localparam fn3_t MULHU_FN3  = 3'd3;

    // Codes 4..7 are divide and remainder, not handled
    localparam fn3_t MUL_FN3_MAX = 3'd3;

    // ALU ops, ADD and SR split further by funct7 bit 5
    localparam fn3_t ADD_FN3  = 3'd0;
    localparam fn3_t SLL_FN3  = 3'd1;
    localparam fn3_t SLT_FN3  = 3'd2;
    localparam fn3_t SLTU_FN3 = 3'd3;
    localparam fn3_t XOR_FN3  = 3'd4;
    localparam fn3_t SR_FN3   = 3'd5;
    localparam fn3_t OR_FN3   = 3'd6;
    localparam fn3_t AND_FN3  = 3'd7;

    // Last writeback winner
    typedef enum logic {LAST_ALU, LAST_MUL} grant_t;

endpackage

`default_nettype wire

//--- hdl/issue_decoder.sv
// Steers one read instruction per cycle to the multiply or ALU unit
// Flags words that neither unit executes and accepts them with no writeback
`timescale 1ns/100ps
`default_nettype none

module issue_decoder
    import exec_cfg_pkg::*;
    import rv_isa_pkg::*;
(
    input  wire logic   issue_valid,
    input  wire instr_t issue_instr,
    input  wire logic   mul_ready,
    input  wire logic   alu_ready,
    output logic        issue_ready,
    output logic        mul_new_request,
    output logic        alu_new_request,
    output logic        issue_illegal,
    output fn3_t        fn3,
    output logic        fn7_alt
);

    logic [6:0] opcode;
    logic [6:0] fn7;
    logic       is_op;
    logic       is_mul;
    logic       is_alu;
    logic       accept;

    ////////////////////////////////////////////////////////////////////////////
    // Field extraction

    assign opcode  = issue_instr[6:0];
    assign fn3     = issue_instr[14:12];
    assign fn7     = issue_instr[31:25];
    // Only bit 5 matters to the ALU, SUB and SRA
    assign fn7_alt = fn7[5];

    ////////////////////////////////////////////////////////////////////////////
    // Classification

    assign is_op = (opcode == OPC_OP);

    // Divide codes share FN7_MULDIV but are not supported
    assign is_mul = is_op && (fn7 == FN7_MULDIV) && (fn3 <= MUL_FN3_MAX);

    // ALT form exists only for SUB and SRA
    assign is_alu = is_op &&
                    ((fn7 == FN7_BASE) ||
                     ((fn7 == FN7_ALT) && ((fn3 == ADD_FN3) || (fn3 == SR_FN3))));

    // Illegal words never wait on a unit
    assign issue_ready = is_mul ? mul_ready :
                         is_alu ? alu_ready : 1'b1;

    assign accept = issue_valid && issue_ready;

    // One pulse per accepted word
    assign mul_new_request = accept && is_mul;
    assign alu_new_request = accept && is_alu;
    assign issue_illegal   = accept && !is_mul && !is_alu;

    ////////////////////////////////////////////////////////////////////////////
    // Checks

    // Exactly one destination per accepted word
    always_comb begin
        assert ($onehot0({mul_new_request, alu_new_request, issue_illegal}))
            else $error("issue_decoder raised more than one pulse");
    end

endmodule

`default_nettype wire

//--- hdl/mul_unit.sv
// Two-stage pipelined multiplier for MUL, MULH, MULHSU and MULHU
// Operands registered in stage 1, product in stage 2, result held until ack
`timescale 1ns/100ps
`default_nettype none

module mul_unit
    import exec_cfg_pkg::*;
    import rv_isa_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  new_request,
    input  wire fn3_t  fn3,
    input  wire word_t rs1,
    input  wire word_t rs2,
    input  wire id_t   id,
    input  wire logic  ack,
    output logic       ready,
    output logic       done,
    output word_t      rd,
    output id_t        rd_id
);

    logic                   rs1_signed;
    logic                   rs2_signed;
    logic signed [XLEN:0]   rs1_ext;
    logic signed [XLEN:0]   rs2_ext;
    logic signed [XLEN:0]   rs1_q;
    logic signed [XLEN:0]   rs2_q;
    logic [2*XLEN-1:0]      product_q;

    logic valid_s1;
    logic valid_s2;
    logic mulh_s1;
    logic mulh_s2;
    id_t  id_s1;
    id_t  id_s2;

    logic stage1_advance;
    logic stage2_advance;

    ////////////////////////////////////////////////////////////////////////////
    // Operand extension

    // Low half of MUL is the same either way
    assign rs1_signed = (fn3 == MULH_FN3) || (fn3 == MULHSU_FN3);
    assign rs2_signed = (fn3 == MULH_FN3);

    // 33-bit signed covers every signed/unsigned mix
    assign rs1_ext = signed'({rs1[XLEN-1] & rs1_signed, rs1});
    assign rs2_ext = signed'({rs2[XLEN-1] & rs2_signed, rs2});

    // Stall chain, last stage frees up on ack
    assign stage2_advance = !valid_s2 || ack;
    assign stage1_advance = !valid_s1 || stage2_advance;
    assign ready          = stage1_advance;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath

    always_ff @(posedge clk) begin
        if (stage1_advance) begin
            rs1_q <= rs1_ext;
            rs2_q <= rs2_ext;
        end
        // Keep the low 64 bits of the 66-bit product
        if (stage2_advance) begin
            product_q <= (2*XLEN)'(rs1_q * rs2_q);
        end
    end

    // Attributes follow the operands
    always_ff @(posedge clk) begin
        if (stage1_advance) begin
            mulh_s1 <= (fn3 != MUL_FN3);
            id_s1   <= id;
        end
        if (stage2_advance) begin
            mulh_s2 <= mulh_s1;
            id_s2   <= id_s1;
        end
    end

    // Occupancy of each stage
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end else begin
            if (stage1_advance) valid_s1 <= new_request;
            if (stage2_advance) valid_s2 <= valid_s1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Writeback side

    assign rd    = mulh_s2 ? product_q[2*XLEN-1:XLEN] : product_q[XLEN-1:0];
    assign done  = valid_s2;
    assign rd_id = id_s2;

    // Result must wait for the arbiter untouched
    assert property (@(posedge clk) disable iff (rst)
        (done && !ack) |=> (done && $stable(rd_id) && $stable(rd)))
        else $error("mul_unit dropped or changed a result before ack");

endmodule

`default_nettype wire

//--- hdl/alu_unit.sv
// Single-cycle RV32 ALU for the R-type OP group
// Result sits in one output register until the writeback arbiter acks it
`timescale 1ns/100ps
`default_nettype none

module alu_unit
    import exec_cfg_pkg::*;
    import rv_isa_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  new_request,
    input  wire fn3_t  fn3,
    input  wire logic  fn7_alt,
    input  wire word_t rs1,
    input  wire word_t rs2,
    input  wire id_t   id,
    input  wire logic  ack,
    output logic       ready,
    output logic       done,
    output word_t      rd,
    output id_t        rd_id
);

    logic [4:0] shamt;
    word_t      result;
    logic       valid_q;
    word_t      rd_q;
    id_t        id_q;

    ////////////////////////////////////////////////////////////////////////////
    // Combinational result

    // RV32 shifts use the low five bits only
    assign shamt = rs2[4:0];

    always_comb begin
        case (fn3)
            ADD_FN3:  result = fn7_alt ? (rs1 - rs2) : (rs1 + rs2);
            SLL_FN3:  result = rs1 << shamt;
            SLT_FN3:  result = word_t'($signed(rs1) < $signed(rs2));
            SLTU_FN3: result = word_t'(rs1 < rs2);
            XOR_FN3:  result = rs1 ^ rs2;
            // SRA keeps the sign
            SR_FN3:   result = fn7_alt ? word_t'($signed(rs1) >>> shamt) : (rs1 >> shamt);
            OR_FN3:   result = rs1 | rs2;
            default:  result = rs1 & rs2;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register

    // Free when empty or draining this cycle
    assign ready = !valid_q || ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (new_request) begin
            valid_q <= 1'b1;
        end else if (ack) begin
            valid_q <= 1'b0;
        end
    end

    // Payload only loads on a new request
    always_ff @(posedge clk) begin
        if (new_request) begin
            rd_q <= result;
            id_q <= id;
        end
    end

    assign done  = valid_q;
    assign rd    = rd_q;
    assign rd_id = id_q;

    // Arbiter only acks a unit that has a result
    assert property (@(posedge clk) disable iff (rst) ack |-> done)
        else $error("alu_unit got ack without a pending result");

endmodule

`default_nettype wire

//--- hdl/wb_arbiter.sv
// Round-robin owner of the shared writeback bus
// Picks one finished unit per cycle, acks it and drives its result out
`timescale 1ns/100ps
`default_nettype none

module wb_arbiter
    import exec_cfg_pkg::*;
    import rv_isa_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  mul_done,
    input  wire logic  alu_done,
    input  wire logic  wb_hold,
    input  wire word_t mul_rd,
    input  wire word_t alu_rd,
    input  wire id_t   mul_id,
    input  wire id_t   alu_id,
    output logic       mul_ack,
    output logic       alu_ack,
    output logic       wb_valid,
    output word_t      wb_rd,
    output id_t        wb_id
);

    grant_t last_q;
    logic   pick_mul;

    ////////////////////////////////////////////////////////////////////////////
    // Grant

    // Lone requester wins, a tie goes to whoever lost last time
    assign pick_mul = mul_done && (!alu_done || (last_q == LAST_ALU));

    // No transfer while the consumer holds
    assign mul_ack  = pick_mul && !wb_hold;
    assign alu_ack  = !pick_mul && alu_done && !wb_hold;
    assign wb_valid = mul_ack || alu_ack;

    // Bus mux follows the grant
    assign wb_rd = pick_mul ? mul_rd : alu_rd;
    assign wb_id = pick_mul ? mul_id : alu_id;

    ////////////////////////////////////////////////////////////////////////////
    // Fairness state

    // Start as if MUL had won so the first tie goes to the ALU
    always_ff @(posedge clk) begin
        if (rst) begin
            last_q <= LAST_MUL;
        end else if (mul_ack) begin
            last_q <= LAST_MUL;
        end else if (alu_ack) begin
            last_q <= LAST_ALU;
        end
    end

    // Single bus, so one winner at a time
    assert property (@(posedge clk) disable iff (rst) !(mul_ack && alu_ack))
        else $error("wb_arbiter acked both units");

endmodule

`default_nettype wire

//--- hdl/exec_top.sv
// Integer execution back end: issue decoder, multiply and ALU units,
// and the shared writeback arbiter
`timescale 1ns/100ps
`default_nettype none

module exec_top
    import exec_cfg_pkg::*;
    import rv_isa_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   issue_valid,
    input  wire instr_t issue_instr,
    input  wire word_t  issue_rs1,
    input  wire word_t  issue_rs2,
    input  wire id_t    issue_id,
    input  wire logic   wb_hold,
    output logic        issue_ready,
    output logic        issue_illegal,
    output logic        wb_valid,
    output word_t       wb_rd,
    output id_t         wb_id
);

    // Issue side
    logic mul_new_request;
    logic alu_new_request;
    fn3_t fn3;
    logic fn7_alt;

    // Unit status
    logic  mul_ready;
    logic  mul_done;
    logic  mul_ack;
    word_t mul_rd;
    id_t   mul_id;
    logic  alu_ready;
    logic  alu_done;
    logic  alu_ack;
    word_t alu_rd;
    id_t   alu_id;

    ////////////////////////////////////////////////////////////////////////////
    // Instances

    issue_decoder u_decoder (
        .issue_valid     (issue_valid),
        .issue_instr     (issue_instr),
        .mul_ready       (mul_ready),
        .alu_ready       (alu_ready),
        .issue_ready     (issue_ready),
        .mul_new_request (mul_new_request),
        .alu_new_request (alu_new_request),
        .issue_illegal   (issue_illegal),
        .fn3             (fn3),
        .fn7_alt         (fn7_alt)
    );

    // Operands and id fan out to both units
    mul_unit u_mul (
        .clk         (clk),
        .rst         (rst),
        .new_request (mul_new_request),
        .fn3         (fn3),
        .rs1         (issue_rs1),
        .rs2         (issue_rs2),
        .id          (issue_id),
        .ack         (mul_ack),
        .ready       (mul_ready),
        .done        (mul_done),
        .rd          (mul_rd),
        .rd_id       (mul_id)
    );

    alu_unit u_alu (
        .clk         (clk),
        .rst         (rst),
        .new_request (alu_new_request),
        .fn3         (fn3),
        .fn7_alt     (fn7_alt),
        .rs1         (issue_rs1),
        .rs2         (issue_rs2),
        .id          (issue_id),
        .ack         (alu_ack),
        .ready       (alu_ready),
        .done        (alu_done),
        .rd          (alu_rd),
        .rd_id       (alu_id)
    );

    wb_arbiter u_arbiter (
        .clk      (clk),
        .rst      (rst),
        .mul_done (mul_done),
        .alu_done (alu_done),
        .wb_hold  (wb_hold),
        .mul_rd   (mul_rd),
        .alu_rd   (alu_rd),
        .mul_id   (mul_id),
        .alu_id   (alu_id),
        .mul_ack  (mul_ack),
        .alu_ack  (alu_ack),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_id    (wb_id)
    );

endmodule

`default_nettype wire

//--- bench/exec_tb.sv
// Testbench for the execution back end, driven through exec_top
// Random RV32 OP and multiply words, id scoreboard, writeback back-pressure
`timescale 1ns/100ps
`default_nettype none

module exec_tb
    import exec_cfg_pkg::*;
    import rv_isa_pkg::*;
();

    localparam int          CLK_PERIOD     = 40;
    localparam logic [31:0] SEED           = 32'h0e848393;
    localparam int          ID_COUNT       = 1 << ID_W;
    localparam int          N_MUL_RAND     = 300;
    localparam int          N_ALU_EACH     = 40;
    localparam int          N_MIX          = 400;
    localparam int          N_HOLD         = 150;
    localparam int          N_HOLD_STRETCH = 12;
    localparam int          N_ILLEGAL_EACH = 4;
    // Corners, random multiplies, ALU, mix, hold, illegal
    localparam int N_INSTR = 100 + 4 * N_MUL_RAND + 10 * N_ALU_EACH + N_MIX + N_HOLD
                             + 3 * N_ILLEGAL_EACH;
    localparam logic [6:0] OPC_R = 7'b0110011;

    logic   clk;
    logic   rst;
    logic   issue_valid;
    instr_t issue_instr;
    word_t  issue_rs1;
    word_t  issue_rs2;
    id_t    issue_id;
    logic   wb_hold;
    logic   issue_ready;
    logic   issue_illegal;
    logic   wb_valid;
    word_t  wb_rd;
    id_t    wb_id;

    // Scoreboard indexed by id
    word_t       expected [0:ID_COUNT-1];
    logic        pending  [0:ID_COUNT-1];
    id_t         next_id;
    logic        ready_dropped;
    logic [31:0] rng_state;
    logic [31:0] hold_state;
    word_t       corners  [0:4] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

    exec_top dut0 (
        .clk           (clk),
        .rst           (rst),
        .issue_valid   (issue_valid),
        .issue_instr   (issue_instr),
        .issue_rs1     (issue_rs1),
        .issue_rs2     (issue_rs2),
        .issue_id      (issue_id),
        .wb_hold       (wb_hold),
        .issue_ready   (issue_ready),
        .issue_illegal (issue_illegal),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_id         (wb_id)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // R-type word with fixed register fields
    function automatic instr_t make_r(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [6:0] opc);
        return {f7, 5'd3, 5'd2, f3, 5'd1, opc};
    endfunction

    // ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
    function automatic instr_t alu_word(input int k);
        case (k)
            0:       return make_r(7'h00, 3'd0, OPC_R);
            1:       return make_r(7'h20, 3'd0, OPC_R);
            2:       return make_r(7'h00, 3'd1, OPC_R);
            3:       return make_r(7'h00, 3'd2, OPC_R);
            4:       return make_r(7'h00, 3'd3, OPC_R);
            5:       return make_r(7'h00, 3'd4, OPC_R);
            6:       return make_r(7'h00, 3'd5, OPC_R);
            7:       return make_r(7'h20, 3'd5, OPC_R);
            8:       return make_r(7'h00, 3'd6, OPC_R);
            default: return make_r(7'h00, 3'd7, OPC_R);
        endcase
    endfunction

    // Ten ALU ops against four multiplies
    function automatic instr_t random_legal();
        logic [31:0] r;
        r = next_rand() % 14;
        if (r < 10) begin
            return alu_word(int'(r));
        end
        return make_r(7'h01, {1'b0, r[1:0]}, OPC_R);
    endfunction

    function automatic logic is_legal(input instr_t w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        if (w[6:0] != OPC_R) begin
            return 1'b0;
        end
        return (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5)) ||
               ((f7 == 7'h01) && (f3 < 3'd4));
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model for RV32I OP and RV32M multiply rules

    function automatic word_t exec_ref(input instr_t w, input word_t a, input word_t b);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  sh;
        logic [63:0] xa;
        logic [63:0] xb;
        logic [63:0] prod;
        word_t       res;
        f3 = w[14:12];
        f7 = w[31:25];
        sh = b[4:0];
        if (f7 == 7'h01) begin
            // rs1 signed for MULH and MULHSU, rs2 only for MULH
            xa   = {{32{a[31] & (f3 == 3'd1 || f3 == 3'd2)}}, a};
            xb   = {{32{b[31] & (f3 == 3'd1)}}, b};
            prod = xa * xb;
            return (f3 == 3'd0) ? prod[31:0] : prod[63:32];
        end
        case (f3)
            3'd0:    res = f7[5] ? a - b : a + b;
            3'd1:    res = a << sh;
            // Signed compare by flipping the sign bits
            3'd2:    res = {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            3'd3:    res = {31'd0, a < b};
            3'd4:    res = a ^ b;
            3'd5:    res = (a >> sh) | ((f7[5] && a[31]) ? ~(32'hffff_ffff >> sh) : 32'd0);
            3'd6:    res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Failure, issue and drain

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    function automatic int count_pending();
        int n;
        n = 0;
        for (int i = 0; i < ID_COUNT; i++) begin
            if (pending[i]) n++;
        end
        return n;
    endfunction

    // Called at a rising edge, returns at the accepting edge
    task automatic issue(input instr_t w, input word_t a, input word_t b);
        logic legal;
        logic accepted;
        id_t  tag;
        legal = is_legal(w);
        tag   = next_id;
        if (pending[tag]) begin
            issue_valid <= 1'b0;
            while (pending[tag]) @(posedge clk);
        end
        issue_valid <= 1'b1;
        issue_instr <= w;
        issue_rs1   <= a;
        issue_rs2   <= b;
        issue_id    <= tag;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = issue_ready;
        end
        assert (issue_illegal == !legal) else begin
            $display("[ERROR] %0t ns issue_illegal got %b expected %b",
                     $time, issue_illegal, !legal);
            abort_run();
        end
        if (legal) begin
            expected[tag] = exec_ref(w, a, b);
            pending[tag]  = 1'b1;
            next_id       = tag + id_t'(1);
        end
    endtask

    task automatic wait_drain();
        issue_valid <= 1'b0;
        while (count_pending() != 0) @(posedge clk);
    endtask

    // Random hold and release windows on the writeback bus
    task automatic hold_stretches();
        repeat (N_HOLD_STRETCH) begin
            hold_state = xorshift32(hold_state);
            wb_hold <= 1'b1;
            repeat (5 + hold_state % 16) @(posedge clk);
            wb_hold <= 1'b0;
            repeat (1 + hold_state[15:0] % 6) @(posedge clk);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Writeback compare

    always @(posedge clk) begin
        if (!rst) begin
            assert (!(wb_hold && wb_valid)) else begin
                $display("[ERROR] %0t ns wb_valid got 1 expected 0 under wb_hold", $time);
                abort_run();
            end
            if (wb_hold && issue_valid && !issue_ready) begin
                ready_dropped = 1'b1;
            end
            if (wb_valid) begin
                assert (pending[wb_id]) else begin
                    $display("Writeback at %0t ns for id %0d, which is not outstanding",
                             $time, wb_id);
                    abort_run();
                end
                assert (wb_rd == expected[wb_id]) else begin
                    $display("[ERROR] %0t ns wb_rd got %h expected %h (id %0d)",
                             $time, wb_rd, expected[wb_id], wb_id);
                    abort_run();
                end
                pending[wb_id] = 1'b0;
            end
        end
    end

    // Bound from the instruction count
    initial begin
        #(CLK_PERIOD * (N_INSTR * 20 + 1000));
        $display("Watchdog expired at %0t ns, results never drained", $time);
        abort_run();
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        word_t       a;
        word_t       b;
        logic [31:0] r;
        clk           = 1'b0;
        rst           = 1'b1;
        issue_valid   = 1'b0;
        issue_instr   = '0;
        issue_rs1     = '0;
        issue_rs2     = '0;
        issue_id      = '0;
        wb_hold       = 1'b0;
        next_id       = '0;
        ready_dropped = 1'b0;
        rng_state     = SEED;
        hold_state    = xorshift32(~SEED);
        for (int i = 0; i < ID_COUNT; i++) begin
            pending[i]  = 1'b0;
            expected[i] = '0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Idle state out of reset
        assert (!wb_valid && !issue_illegal && issue_ready) else begin
            $display("[ERROR] %0t ns wb_valid/issue_illegal/issue_ready got %b%b%b expected 001",
                     $time, wb_valid, issue_illegal, issue_ready);
            abort_run();
        end

        // Every corner pair for every multiply op
        for (int op = 0; op < 4; op++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    issue(make_r(7'h01, 3'(op), OPC_R), corners[i], corners[j]);
                end
            end
        end
        for (int i = 0; i < N_MUL_RAND; i++) begin
            a = next_rand();
            b = next_rand();
            for (int op = 0; op < 4; op++) begin
                issue(make_r(7'h01, 3'(op), OPC_R), a, b);
            end
        end
        wait_drain();

        // ALU ops with random rs2, which also covers large shift amounts
        for (int k = 0; k < 10; k++) begin
            for (int i = 0; i < N_ALU_EACH; i++) begin
                a = next_rand();
                b = next_rand();
                issue(alu_word(k), a, b);
            end
        end
        wait_drain();

        // Back-to-back mix where results may return out of order
        for (int i = 0; i < N_MIX; i++) begin
            a = next_rand();
            b = next_rand();
            issue(random_legal(), a, b);
        end
        wait_drain();

        // Mix under writeback back-pressure
        fork
            hold_stretches();
            for (int i = 0; i < N_HOLD; i++) begin
                a = next_rand();
                b = next_rand();
                issue(random_legal(), a, b);
            end
        join
        wait_drain();
        assert (ready_dropped) else begin
            $display("issue_ready never dropped while the writeback bus was held");
            abort_run();
        end

        // Divide codes, foreign opcodes, ALT with XOR
        for (int i = 0; i < N_ILLEGAL_EACH; i++) begin
            r = next_rand();
            issue(make_r(7'h01, 3'd4 + r[1:0], OPC_R), r, ~r);
            issue(make_r(7'h00, r[4:2], (r[6:0] == OPC_R) ? 7'b0010011 : r[6:0]), r, r);
            issue(make_r(7'h20, 3'd4, OPC_R), r, ~r);
        end
        issue_valid <= 1'b0;
        // Quiet window so a stray writeback hits the compare process
        repeat (6) @(posedge clk);

        assert (count_pending() == 0) else begin
            $display("%0d results still outstanding at the end", count_pending());
            abort_run();
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
hdl/exec_cfg_pkg.sv
hdl/rv_isa_pkg.sv
hdl/issue_decoder.sv
hdl/mul_unit.sv
hdl/alu_unit.sv
hdl/wb_arbiter.sv
hdl/exec_top.sv
bench/exec_tb.sv

//--- run.sh
#!/bin/sh
# Build the execution back end testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module exec_tb --Mdir obj_dir -o exec_sim \
    -f sources.f

status=0
./obj_dir/exec_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "TB PASSED" sim.log; then
    echo "Simulation ended without a pass verdict"
    exit 1
fi
